// ==== hw/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int DATA_BITS       = 63;
    localparam int CHECK_BITS      = 8;
    localparam int WORD_BITS       = DATA_BITS + CHECK_BITS;
    localparam int ADDR_BITS       = 6;
    localparam int STORE_DEPTH     = 1 << ADDR_BITS;
    localparam int REQ_DEPTH       = 4;
    localparam int REQ_PTR_BITS    = $clog2(REQ_DEPTH);
    localparam int RSP_DEPTH       = 4;
    localparam int RSP_PTR_BITS    = $clog2(RSP_DEPTH);
    localparam int RSP_CREDITS     = 2;
    localparam int RSP_CREDIT_BITS = $clog2(RSP_CREDITS + 1);
    localparam int CNT_BITS        = 16;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } ecc_op_e;

    typedef struct packed {
        ecc_op_e                op;
        logic [ADDR_BITS-1:0]   addr;
        logic [DATA_BITS-1:0]   data;
        logic [WORD_BITS-1:0]   flip;    // fault injection mask, writes only
        logic                   bypass;  // reads only
    } ecc_req_t;

    typedef struct packed {
        logic [DATA_BITS-1:0]   data;
        logic                   sbit_err;
        logic                   dbit_err;
    } ecc_rsp_t;

    typedef union packed {
        struct packed {
            logic [CHECK_BITS-1:0] parity;
            logic [DATA_BITS-1:0]  data;
        } fields;
        logic [WORD_BITS-1:0] bits;
    } ecc_word_u;

    // syndrome column of data bit i, low 7 bits are the hamming position
    function automatic logic [CHECK_BITS-1:0] ecc_column(input int i);
        logic [CHECK_BITS-2:0] pos;
        pos = 7'(i + 3);
        for (int k = 2; k < CHECK_BITS - 1; k++) begin
            if (pos >= 7'(1 << k)) begin
                pos = pos + 7'd1;  // skip check bit slot
            end
        end
        return {~^pos, pos};  // top bit keeps column weight odd
    endfunction

    function automatic logic [CHECK_BITS-1:0] ecc_encode(input logic [DATA_BITS-1:0] d);
        logic [CHECK_BITS-1:0] p;
        p = '0;
        for (int i = 0; i < DATA_BITS; i++) begin
            if (d[i]) begin
                p = p ^ ecc_column(i);
            end
        end
        return p;
    endfunction

endpackage

`default_nettype wire

// ==== hw/ecc_63_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_63_top (
    input  ecc_pkg::ecc_word_u            codeword,
    input  logic                          bypass,
    output logic [ecc_pkg::DATA_BITS-1:0] data_out,
    output logic                          sbit_err,
    output logic                          dbit_err
);
    import ecc_pkg::*;

    logic [CHECK_BITS-1:0] syndrome;
    logic [DATA_BITS-1:0]  mask;
    logic                  data_hit;
    logic                  check_hit;
    logic                  sbit;
    logic                  dbit;

    assign syndrome = codeword.fields.parity ^ ecc_encode(codeword.fields.data);

    always_comb begin
        mask = '0;
        for (int i = 0; i < DATA_BITS; i++) begin
            mask[i] = (syndrome == ecc_column(i));
        end
    end

    assign data_hit  = |mask;
    // a lone syndrome bit points at a check bit
    assign check_hit = (syndrome != '0) && ((syndrome & (syndrome - 8'd1)) == '0);

    assign sbit = data_hit || check_hit;
    assign dbit = (syndrome != '0) && !sbit;  // no column matched

    assign data_out = bypass ? codeword.fields.data : codeword.fields.data ^ mask;
    assign sbit_err = bypass ? 1'b0 : sbit;
    assign dbit_err = bypass ? 1'b0 : dbit;

    // data columns are distinct and never a lone bit
    always_comb begin
        assert ($onehot0(mask) && !(data_hit && check_hit))
            else $error("ecc_63_top: syndrome matches more than one bit position");
    end

endmodule

`default_nettype wire

// ==== hw/ecc_req_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_req_fifo (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  ecc_pkg::ecc_req_t req,
    input  logic              pop,
    output ecc_pkg::ecc_req_t head,
    output logic              nonempty,
    output logic              req_credit
);
    import ecc_pkg::*;

    ecc_req_t                slots [REQ_DEPTH];
    logic [REQ_PTR_BITS-1:0] wr_ptr;
    logic [REQ_PTR_BITS-1:0] rd_ptr;
    logic [REQ_PTR_BITS:0]   count;

    assign head     = slots[rd_ptr];
    assign nonempty = (count != '0);

    always_ff @(posedge clk) begin
        if (req_valid) begin
            slots[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count      <= count + (REQ_PTR_BITS + 1)'(req_valid)
                                - (REQ_PTR_BITS + 1)'(pop);
            req_credit <= pop;  // one credit back per pop
        end
    end

    // host must hold a credit for every request
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> count < (REQ_PTR_BITS + 1)'(REQ_DEPTH));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> nonempty);

endmodule

`default_nettype wire

// ==== hw/ecc_word_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_word_mem (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [ecc_pkg::ADDR_BITS-1:0] wr_addr,
    input  ecc_pkg::ecc_word_u            wr_word,
    input  logic                          rd_en,
    input  logic [ecc_pkg::ADDR_BITS-1:0] rd_addr,
    output ecc_pkg::ecc_word_u            rd_word
);
    import ecc_pkg::*;

    ecc_word_u words [STORE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            words[wr_addr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= words[rd_addr];  // registered read
        end
    end

endmodule

`default_nettype wire

// ==== hw/ecc_store_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_store_core (
    input  logic                          clk,
    input  logic                          reset,
    input  ecc_pkg::ecc_req_t             head,
    input  logic                          nonempty,
    output logic                          pop,
    input  logic                          can_reserve,
    output logic                          reserve,
    output logic                          push,
    output ecc_pkg::ecc_rsp_t             rsp_out,
    output logic                          mem_wr_en,
    output logic [ecc_pkg::ADDR_BITS-1:0] mem_wr_addr,
    output ecc_pkg::ecc_word_u            mem_wr_word,
    output logic                          mem_rd_en,
    output logic [ecc_pkg::ADDR_BITS-1:0] mem_rd_addr,
    input  ecc_pkg::ecc_word_u            mem_rd_word,
    output logic [ecc_pkg::CNT_BITS-1:0]  sbit_count,
    output logic [ecc_pkg::CNT_BITS-1:0]  dbit_count
);
    import ecc_pkg::*;

    logic                 is_read;
    ecc_word_u            enc_word;
    logic                 rd_pending;
    logic                 rd_bypass;
    logic [DATA_BITS-1:0] dec_data;
    logic                 dec_sbit;
    logic                 dec_dbit;

    assign is_read = (head.op == op_read);
    assign pop     = nonempty && (!is_read || can_reserve);  // writes never wait
    assign reserve = pop && is_read;

    always_comb begin
        enc_word.fields.data   = head.data;
        enc_word.fields.parity = ecc_encode(head.data);
        mem_wr_word.bits       = enc_word.bits ^ head.flip;  // injected faults
    end

    assign mem_wr_en   = pop && !is_read;
    assign mem_wr_addr = head.addr;
    assign mem_rd_en   = reserve;
    assign mem_rd_addr = head.addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
            push       <= 1'b0;
        end else begin
            rd_pending <= reserve;
            push       <= rd_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (reserve) begin
            rd_bypass <= head.bypass;  // travels with the memory read
        end
        if (rd_pending) begin
            rsp_out.data     <= dec_data;
            rsp_out.sbit_err <= dec_sbit;
            rsp_out.dbit_err <= dec_dbit;
        end
    end

    ecc_63_top ecc_63_top_i (
        .codeword (mem_rd_word),
        .bypass   (rd_bypass),
        .data_out (dec_data),
        .sbit_err (dec_sbit),
        .dbit_err (dec_dbit)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else if (rd_pending) begin
            if (dec_sbit && !(&sbit_count)) begin
                sbit_count <= sbit_count + 1'b1;  // saturates
            end
            if (dec_dbit && !(&dbit_count)) begin
                dbit_count <= dbit_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ecc_rsp_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_rsp_port (
    input  logic              clk,
    input  logic              reset,
    input  logic              reserve,
    input  logic              push,
    input  ecc_pkg::ecc_rsp_t rsp_in,
    output logic              can_reserve,
    output logic              rsp_valid,
    output ecc_pkg::ecc_rsp_t rsp,
    input  logic              rsp_credit
);
    import ecc_pkg::*;

    ecc_rsp_t                   slots [RSP_DEPTH];
    logic [RSP_PTR_BITS-1:0]    wr_ptr;
    logic [RSP_PTR_BITS-1:0]    rd_ptr;
    logic [RSP_PTR_BITS:0]      count;
    logic [RSP_PTR_BITS:0]      reserved;
    logic [RSP_PTR_BITS:0]      occupied;
    logic [RSP_CREDIT_BITS-1:0] credits;
    logic                       empty;
    logic                       store;
    logic                       unload;

    assign empty       = (count == '0);
    assign occupied    = reserved + count;
    assign can_reserve = occupied < (RSP_PTR_BITS + 1)'(RSP_DEPTH);

    // fall through when the buffer is empty
    assign rsp_valid = (credits != '0) && (!empty || push);
    assign rsp       = empty ? rsp_in : slots[rd_ptr];
    assign store     = push && !(empty && rsp_valid);
    assign unload    = rsp_valid && !empty;

    always_ff @(posedge clk) begin
        if (store) begin
            slots[wr_ptr] <= rsp_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            reserved <= '0;
            credits  <= RSP_CREDIT_BITS'(RSP_CREDITS);
        end else begin
            if (store) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (unload) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count + (RSP_PTR_BITS + 1)'(store) - (RSP_PTR_BITS + 1)'(unload);
            reserved <= reserved + (RSP_PTR_BITS + 1)'(reserve)
                                 - (RSP_PTR_BITS + 1)'(push);
            credits  <= credits + RSP_CREDIT_BITS'(rsp_credit)
                                - RSP_CREDIT_BITS'(rsp_valid);
        end
    end

    // core pushes only what it reserved two cycles back
    a_push_reserved: assert property (@(posedge clk) disable iff (reset)
        push |-> reserved != '0);

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= RSP_CREDIT_BITS'(RSP_CREDITS));

endmodule

`default_nettype wire

// ==== hw/ecc_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_store (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  ecc_pkg::ecc_req_t            req,
    output logic                         req_credit,
    output logic                         rsp_valid,
    output ecc_pkg::ecc_rsp_t            rsp,
    input  logic                         rsp_credit,
    output logic [ecc_pkg::CNT_BITS-1:0] sbit_count,
    output logic [ecc_pkg::CNT_BITS-1:0] dbit_count
);
    import ecc_pkg::*;

    ecc_req_t             head;
    logic                 nonempty;
    logic                 pop;
    logic                 can_reserve;
    logic                 reserve;
    logic                 push;
    ecc_rsp_t             core_rsp;
    logic                 mem_wr_en;
    logic [ADDR_BITS-1:0] mem_wr_addr;
    ecc_word_u            mem_wr_word;
    logic                 mem_rd_en;
    logic [ADDR_BITS-1:0] mem_rd_addr;
    ecc_word_u            mem_rd_word;

    ecc_req_fifo ecc_req_fifo_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .pop        (pop),
        .head       (head),
        .nonempty   (nonempty),
        .req_credit (req_credit)
    );

    ecc_store_core ecc_store_core_i (
        .clk         (clk),
        .reset       (reset),
        .head        (head),
        .nonempty    (nonempty),
        .pop         (pop),
        .can_reserve (can_reserve),
        .reserve     (reserve),
        .push        (push),
        .rsp_out     (core_rsp),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_word (mem_wr_word),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_word (mem_rd_word),
        .sbit_count  (sbit_count),
        .dbit_count  (dbit_count)
    );

    ecc_word_mem ecc_word_mem_i (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_word (mem_wr_word),
        .rd_en   (mem_rd_en),
        .rd_addr (mem_rd_addr),
        .rd_word (mem_rd_word)
    );

    ecc_rsp_port ecc_rsp_port_i (
        .clk         (clk),
        .reset       (reset),
        .reserve     (reserve),
        .push        (push),
        .rsp_in      (core_rsp),
        .can_reserve (can_reserve),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_credit  (rsp_credit)
    );

endmodule

`default_nettype wire

// ==== testbench/ecc_store_vectors.svh ====
`ifndef ECC_STORE_VECTORS_SVH
`define ECC_STORE_VECTORS_SVH

typedef struct packed {
    ecc_op_e              op;
    logic [ADDR_BITS-1:0] addr;
    logic                 rand_data;  // draw data from the lcg
    logic [DATA_BITS-1:0] data;
    int                   pos_a;      // flip position or -1 for none
    int                   pos_b;
    logic                 bypass;
    int                   reps;       // addr and flip positions step by one per repeat
} vec_row_t;

vec_row_t rows [$];

function automatic void add_row(input ecc_op_e op, input logic [ADDR_BITS-1:0] addr,
                                input logic rand_data, input logic [DATA_BITS-1:0] data,
                                input int pos_a, input int pos_b, input logic bypass,
                                input int reps);
    vec_row_t row;
    row = '{op, addr, rand_data, data, pos_a, pos_b, bypass, reps};
    rows.push_back(row);
endfunction

function automatic void load_vectors();
    //      op        addr   rnd   data                pos_a pos_b byp   reps
    add_row(op_write, 6'd0,  1'b0, {DATA_BITS{1'b1}},  -1,   -1,   1'b0, 1);
    add_row(op_write, 6'd1,  1'b0, 63'd0,              -1,   -1,   1'b0, 1);
    add_row(op_read,  6'd0,  1'b0, 63'd0,              -1,   -1,   1'b0, 2);
    add_row(op_write, 6'd2,  1'b1, 63'd0,              -1,   -1,   1'b0, 8);
    add_row(op_read,  6'd2,  1'b0, 63'd0,              -1,   -1,   1'b0, 8);
    add_row(op_write, 6'd0,  1'b1, 63'd0,              0,    -1,   1'b0, 63);
    add_row(op_read,  6'd0,  1'b0, 63'd0,              -1,   -1,   1'b0, 63);
    add_row(op_read,  6'd0,  1'b0, 63'd0,              -1,   -1,   1'b1, 63);
    add_row(op_write, 6'd0,  1'b1, 63'd0,              63,   -1,   1'b0, 8);  // check bits
    add_row(op_read,  6'd0,  1'b0, 63'd0,              -1,   -1,   1'b0, 8);
    add_row(op_read,  6'd0,  1'b0, 63'd0,              -1,   -1,   1'b1, 8);
    add_row(op_write, 6'd8,  1'b1, 63'd0,              0,    40,   1'b0, 31);
    add_row(op_read,  6'd8,  1'b0, 63'd0,              -1,   -1,   1'b0, 31);
    add_row(op_read,  6'd8,  1'b0, 63'd0,              -1,   -1,   1'b1, 31);
endfunction

`endif

// ==== testbench/ecc_store_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_store_tb;
    import ecc_pkg::*;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 req_valid;
    ecc_req_t             req;
    logic                 req_credit;
    logic                 rsp_valid;
    ecc_rsp_t             rsp;
    logic                 rsp_credit;
    logic [CNT_BITS-1:0]  sbit_count;
    logic [CNT_BITS-1:0]  dbit_count;

    logic [DATA_BITS-1:0] model_data [STORE_DEPTH];
    logic [WORD_BITS-1:0] model_flip [STORE_DEPTH];
    ecc_rsp_t             expected [$];
    logic [31:0]          data_state = 32'hfdc0;
    logic [31:0]          delay_state = 32'hfdc0;
    int                   exp_sbit = 0;
    int                   exp_dbit = 0;
    int                   sent = 0;
    int                   credit_returns = 0;
    int                   rsp_seen = 0;
    int                   owed = 0;  // response credits the consumer still has to give back
    int                   total_reqs = 0;
    int                   total_reads = 0;

    `include "ecc_store_vectors.svh"

    ecc_store ecc_store_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit),
        .sbit_count (sbit_count),
        .dbit_count (dbit_count)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [WORD_BITS-1:0] flip_mask(input int pos_a, input int pos_b);
        logic [WORD_BITS-1:0] m;
        m = '0;
        if (pos_a >= 0) begin
            m[pos_a % WORD_BITS] = 1'b1;
        end
        if (pos_b >= 0) begin
            m[pos_b % WORD_BITS] = 1'b1;
        end
        return m;
    endfunction

    // secded rules applied to the written data and its injected flips
    function automatic ecc_rsp_t expect_read(input logic [DATA_BITS-1:0] d,
                                             input logic [WORD_BITS-1:0] f, input logic bypass);
        ecc_rsp_t r;
        r.data = d ^ f[DATA_BITS-1:0];  // stored data bits
        r.sbit_err = 1'b0;
        r.dbit_err = 1'b0;
        if (!bypass && $countones(f) == 1) begin
            r.data = d;
            r.sbit_err = 1'b1;
        end else if (!bypass && $countones(f) == 2) begin
            r.dbit_err = 1'b1;
        end
        return r;
    endfunction

    task automatic check_rsp(input ecc_rsp_t got, input ecc_rsp_t exp);
        if (got !== exp) begin
            $display("error: %0t ns: rsp data %h sbit %b dbit %b, expected data %h sbit %b dbit %b",
                     $time, got.data, got.sbit_err, got.dbit_err,
                     exp.data, exp.sbit_err, exp.dbit_err);
            $display("Test failures found");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_counts(input logic [CNT_BITS-1:0] got_s, input logic [CNT_BITS-1:0] got_d,
                                input logic [CNT_BITS-1:0] exp_s, input logic [CNT_BITS-1:0] exp_d);
        if (got_s !== exp_s || got_d !== exp_d) begin
            $display("error: %0t ns: counters sbit %0d dbit %0d, expected sbit %0d dbit %0d",
                     $time, got_s, got_d, exp_s, exp_d);
            $display("Test failures found");
            $fatal(1, "counter mismatch");
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (req_credit === 1'b1) begin
                credit_returns++;
            end
            if (rsp_valid === 1'b1) begin
                if (expected.size() == 0) begin
                    $display("a response arrived with no read outstanding");
                    $display("Test failures found");
                    $fatal(1, "unexpected response");
                end
                check_rsp(rsp, expected.pop_front());
                rsp_seen++;
                owed++;
            end
        end
    end

    initial begin
        int delay;
        int returned;
        returned = 0;
        forever begin
            @(negedge clk);
            if (owed > 0) begin
                returned++;
                delay_state = lcg_step(delay_state);
                delay = (returned % 16 == 0) ? 80 : int'(delay_state[18:16]);  // long stall now and then
                repeat (delay) @(negedge clk);
                rsp_credit = 1'b1;
                owed--;
                @(negedge clk);
                rsp_credit = 1'b0;
            end
        end
    end

    initial begin
        wait (total_reqs > 0);
        repeat (total_reqs * 50) @(posedge clk);
        $display("timeout: responses stopped arriving, %0d of %0d reads answered",
                 rsp_seen, total_reads);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        ecc_req_t    r;
        ecc_rsp_t    e;
        vec_row_t    row;
        logic [31:0] hi;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_credit = 1'b0;
        load_vectors();
        foreach (rows[i]) begin
            total_reqs += rows[i].reps;
            total_reads += (rows[i].op == op_read) ? rows[i].reps : 0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (rows[i]) begin
            row = rows[i];
            for (int k = 0; k < row.reps; k++) begin
                r = '0;
                r.op = row.op;
                r.addr = row.addr + ADDR_BITS'(k);
                r.bypass = row.bypass;
                if (row.op == op_write) begin
                    r.data = row.data;
                    if (row.rand_data) begin
                        data_state = lcg_step(data_state);
                        hi = data_state;
                        data_state = lcg_step(data_state);
                        r.data = {hi[30:0], data_state};
                    end
                    r.flip = flip_mask(row.pos_a < 0 ? -1 : row.pos_a + k,
                                       row.pos_b < 0 ? -1 : row.pos_b + k);
                    model_data[r.addr] = r.data;
                    model_flip[r.addr] = r.flip;
                end else begin
                    e = expect_read(model_data[r.addr], model_flip[r.addr], r.bypass);
                    expected.push_back(e);
                    exp_sbit += e.sbit_err ? 1 : 0;
                    exp_dbit += e.dbit_err ? 1 : 0;
                end
                while (sent - credit_returns >= REQ_DEPTH) begin
                    req_valid = 1'b0;  // out of request credits
                    @(negedge clk);
                end
                req_valid = 1'b1;
                req = r;
                sent++;
                @(negedge clk);
            end
        end
        req_valid = 1'b0;
        while (rsp_seen < total_reads) @(negedge clk);
        repeat (4) @(negedge clk);
        check_counts(sbit_count, dbit_count, CNT_BITS'(exp_sbit), CNT_BITS'(exp_dbit));
        if (credit_returns != sent) begin
            $display("request credits returned %0d for %0d requests sent", credit_returns, sent);
            $display("Test failures found");
            $fatal(1, "request credit mismatch");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+testbench
hw/ecc_pkg.sv
hw/ecc_63_top.sv
hw/ecc_req_fifo.sv
hw/ecc_word_mem.sv
hw/ecc_store_core.sv
hw/ecc_rsp_port.sv
hw/ecc_store.sv
testbench/ecc_store_tb.sv

// ==== Makefile ====
TOP = ecc_store_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
